// ==== Bender.yml ====
package:
  name: lcd_frame

sources:
  - files:
      - verilog/lcd_pkg.sv
      - verilog/lcd_timing.sv
      - verilog/image_rom.sv
      - verilog/image_loader.sv
      - verilog/video_ram.sv
      - verilog/window_addr.sv
      - verilog/pixel_out.sv
      - verilog/lcd_frame.sv
  - target: test
    files:
      - tests/lcd_frame_tb.sv

// ==== lcd_frame.f ====
verilog/lcd_pkg.sv
verilog/lcd_timing.sv
verilog/image_rom.sv
verilog/image_loader.sv
verilog/video_ram.sv
verilog/window_addr.sv
verilog/pixel_out.sv
verilog/lcd_frame.sv
tests/lcd_frame_tb.sv

// ==== tests/lcd_frame_tb.sv ====
`timescale 1ns/1ps

module lcd_frame_tb;

	localparam int H_ACTIVE = 480, H_FRONT = 8, H_SYNC = 4, H_TOTAL = 525;
	localparam int V_ACTIVE = 272, V_FRONT = 4, V_SYNC = 4, V_TOTAL = 288;
	localparam int WIN_X = 160, WIN_Y = 18;
	localparam int LOAD_LIMIT = 1100;
	localparam int SCAN_LIMIT = 2 * H_TOTAL * V_TOTAL;
	localparam logic [1:0] CHECK_SUM = 2'd0, CHECK_ROM = 2'd1, CHECK_FREEZE = 2'd2;

	typedef struct packed {
		logic [15:0] line;
		logic [15:0] pixel;
		logic        freeze;
		logic [1:0]  kind;
	} probe_t;

	logic pixel_clk, rst, freeze, lcd_clk, lcd_hsync, lcd_vsync, lcd_den, load_done;
	logic [4:0] lcd_r;
	logic [5:0] lcd_g;
	logic [4:0] lcd_b;
	probe_t probes [24];
	int num_probes, errors;
	bit timed_out;
	// Scan tracker state and the snapshot of the last sampled cycle.
	int line_idx, pixel_idx, den_count, line_count, frame_no;
	logic den_prev, vsync_prev, load_seen, snap_valid;
	int snap_line, snap_pixel, snap_frame;
	logic [15:0] snap_rgb;

	lcd_frame #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_TOTAL (H_TOTAL),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_TOTAL (V_TOTAL),
		.WIN_X (WIN_X), .WIN_Y (WIN_Y)
	) i_lcd_frame (
		.pixel_clk (pixel_clk), .rst (rst), .freeze (freeze), .lcd_clk (lcd_clk),
		.lcd_hsync (lcd_hsync), .lcd_vsync (lcd_vsync), .lcd_den (lcd_den),
		.lcd_r (lcd_r), .lcd_g (lcd_g), .lcd_b (lcd_b), .load_done (load_done)
	);

	initial begin
		pixel_clk = 1'b0;
		forever #4 pixel_clk = ~pixel_clk;
	end

	// The panel clock is a plain copy of the pixel clock.
	always @(pixel_clk) begin
		#1;
		if (lcd_clk !== pixel_clk) begin
			$display("CHECK FAILED at %0t: lcd_clk %b differs from pixel_clk %b",
				$time, lcd_clk, pixel_clk);
			errors++;
		end
	end

	function automatic bit in_window_ref(input int line, input int pixel);
		return pixel >= WIN_X && pixel < WIN_X + 256
			&& line >= WIN_Y && line < WIN_Y + 256;
	endfunction

	// Expected 16-bit {r, g, b} for a scan position after the image is loaded.
	function automatic logic [15:0] expected_rgb(input int line, input int pixel);
		int addr;
		logic [31:0] c;
		if (in_window_ref(line, pixel)) begin
			addr = ((line - WIN_Y) / 4 % 32) * 32 + (pixel - WIN_X) / 8;
			c = addr * 256 + addr % 256;
		end else begin
			c = line + pixel;
		end
		return {c[17:13], c[17:12], c[17:13]};
	endfunction

	task automatic add_probe(input int line, input int pixel, input logic frz,
			input logic [1:0] kind);
		probes[num_probes] = {16'(line), 16'(pixel), frz, kind};
		num_probes++;
	endtask

	// Waits for the next sampled cycle that shows the given position in frame 1 or later.
	task automatic wait_for_position(input int line, input int pixel, input int limit);
		int cycles;
		bit found;
		cycles = 0;
		found = 0;
		while (!found && cycles < limit) begin
			@(posedge pixel_clk);
			cycles++;
			found = snap_valid && snap_frame >= 1 && snap_line == line && snap_pixel == pixel;
		end
		if (!found) begin
			$display("Timeout: scan never reached line %0d pixel %0d", line, pixel);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic check_pixel(input int line, input int pixel, input logic [15:0] exp);
		if (snap_rgb !== exp) begin
			$display("CHECK FAILED at %0t: line %0d pixel %0d rgb %h, expected %h",
				$time, line, pixel, snap_rgb, exp);
			errors++;
		end
	endtask

	task automatic check_frozen_line(input int line, input logic frz);
		int p, diffs;
		bit seen, lost;
		logic [15:0] held;
		diffs = 0;
		seen = 0;
		lost = 0;
		wait_for_position(line - 1, 0, SCAN_LIMIT);
		if (!timed_out) begin
			#1 freeze = frz;
			wait_for_position(line, 0, 2 * H_TOTAL);
		end
		for (p = 0; p < H_ACTIVE && !timed_out && !lost; p++) begin
			if (p > 0) @(posedge pixel_clk);
			if (!snap_valid || snap_line != line || snap_pixel != p) begin
				$display("Scan tracker lost the position on frozen line %0d at pixel %0d",
					line, p);
				errors++;
				lost = 1;
			end else if (!in_window_ref(line, p)) begin
				check_pixel(line, p, expected_rgb(line, p));
			end else if (!seen) begin
				held = snap_rgb;
				seen = 1;
			end else begin
				check_pixel(line, p, held);
				if (snap_rgb !== expected_rgb(line, p)) diffs++;
			end
		end
		#1 freeze = 1'b0;
		if (!timed_out && !lost && diffs == 0) begin
			$display("CHECK FAILED at %0t: freeze left line %0d unchanged", $time, line);
			errors++;
		end
	endtask

	task automatic apply_probe(input probe_t p);
		if (p.kind == CHECK_FREEZE) begin
			check_frozen_line(p.line, p.freeze);
		end else begin
			if ((p.kind == CHECK_ROM) != in_window_ref(p.line, p.pixel)) begin
				$display("Probe table row at line %0d pixel %0d has the wrong kind",
					p.line, p.pixel);
				errors++;
			end
			wait_for_position(p.line, p.pixel, SCAN_LIMIT);
			if (!timed_out) check_pixel(p.line, p.pixel, expected_rgb(p.line, p.pixel));
		end
	endtask

	// The tracker samples at the falling edge, away from the output updates.
	always @(negedge pixel_clk) begin
		if (!rst) begin
			line_idx = -1;
			pixel_idx = 0;
			den_count = 0;
			line_count = 0;
			frame_no = 0;
			den_prev = 1'b0;
			vsync_prev = 1'b1;
			load_seen = 1'b0;
			snap_valid = 1'b0;
		end else begin
			if (!lcd_vsync && vsync_prev) begin
				if (line_count != V_ACTIVE) begin
					$display("CHECK FAILED at %0t: %0d active lines in frame", $time, line_count);
					errors++;
				end
				frame_no++;
				line_count = 0;
				line_idx = -1;
			end
			if (lcd_den && !den_prev) begin
				line_idx++;
				line_count++;
				pixel_idx = 0;
				den_count = 0;
			end else if (lcd_den) begin
				pixel_idx++;
			end
			if (lcd_den) den_count++;
			if (!lcd_den && den_prev && den_count != H_ACTIVE) begin
				$display("CHECK FAILED at %0t: %0d den cycles on line", $time, den_count);
				errors++;
			end
			if (lcd_den && (!lcd_hsync || !lcd_vsync)) begin
				$display("CHECK FAILED at %0t: den high during a sync pulse", $time);
				errors++;
			end
			if (load_seen && !load_done) begin
				$display("CHECK FAILED at %0t: load_done fell", $time);
				errors++;
			end
			load_seen = load_seen || load_done;
			snap_valid = lcd_den;
			snap_line = line_idx;
			snap_pixel = pixel_idx;
			snap_frame = frame_no;
			snap_rgb = {lcd_r, lcd_g, lcd_b};
			den_prev = lcd_den;
			vsync_prev = lcd_vsync;
		end
	end

	initial begin
		int cycles;
		errors = 0;
		timed_out = 1'b0;
		num_probes = 0;
		rst = 1'b0;
		freeze = 1'b0;
		// Rows in scan order. Line 146 repeats the cells of line 18.
		add_probe(0, 0, 1'b0, CHECK_SUM);
		add_probe(0, 479, 1'b0, CHECK_SUM);
		add_probe(10, 200, 1'b0, CHECK_SUM);
		add_probe(17, 300, 1'b0, CHECK_SUM);
		add_probe(18, 160, 1'b0, CHECK_ROM);
		add_probe(18, 287, 1'b0, CHECK_ROM);
		add_probe(18, 288, 1'b0, CHECK_ROM);
		add_probe(21, 160, 1'b0, CHECK_ROM);
		add_probe(22, 160, 1'b0, CHECK_ROM);
		add_probe(100, 159, 1'b0, CHECK_SUM);
		add_probe(100, 300, 1'b0, CHECK_ROM);
		add_probe(100, 416, 1'b0, CHECK_SUM);
		add_probe(145, 415, 1'b0, CHECK_ROM);
		add_probe(146, 288, 1'b0, CHECK_ROM);
		add_probe(150, 0, 1'b0, CHECK_SUM);
		add_probe(150, 167, 1'b0, CHECK_ROM);
		add_probe(271, 415, 1'b0, CHECK_ROM);
		add_probe(271, 479, 1'b0, CHECK_SUM);
		add_probe(60, 0, 1'b1, CHECK_FREEZE);
		add_probe(200, 0, 1'b1, CHECK_FREEZE);
		repeat (10) @(posedge pixel_clk);
		if (lcd_den !== 1'b0 || lcd_hsync !== 1'b1 || lcd_vsync !== 1'b1
				|| {lcd_r, lcd_g, lcd_b} !== 16'h0 || load_done !== 1'b0) begin
			$display("CHECK FAILED at %0t: outputs in reset den %b hs %b vs %b rgb %h done %b",
				$time, lcd_den, lcd_hsync, lcd_vsync, {lcd_r, lcd_g, lcd_b}, load_done);
			errors++;
		end
		#1 rst = 1'b1;
		cycles = 0;
		while (load_done !== 1'b1 && cycles < LOAD_LIMIT) begin
			@(negedge pixel_clk);
			cycles++;
		end
		if (load_done !== 1'b1) begin
			$display("Timeout: load_done did not rise within %0d cycles", LOAD_LIMIT);
			errors++;
			timed_out = 1'b1;
		end
		cycles = 0;
		while (!timed_out && snap_frame < 1) begin
			@(posedge pixel_clk);
			cycles++;
			if (cycles >= SCAN_LIMIT) begin
				$display("Timeout: the second frame never started");
				errors++;
				timed_out = 1'b1;
			end
		end
		for (int i = 0; i < num_probes && !timed_out; i++) begin
			apply_probe(probes[i]);
		end
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== verilog/image_loader.sv ====
`timescale 1ns/1ps

module image_loader (
	input  logic                pixel_clk,
	input  logic                rst,
	output lcd_pkg::cell_addr_t rom_addr,
	input  lcd_pkg::color_t     rom_data,
	output logic                wr_en,
	output lcd_pkg::cell_addr_t wr_addr,
	output lcd_pkg::color_t     wr_data,
	output logic                load_done
);

	localparam lcd_pkg::cell_addr_t LAST_ADDR = '1;

	lcd_pkg::load_state_t state;

	// ROM data arrives one cycle after its address, so the write address trails rom_addr.
	assign wr_data = rom_data;

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			state     <= lcd_pkg::LOAD_IDLE;
			rom_addr  <= '0;
			wr_en     <= 1'b0;
			wr_addr   <= '0;
			load_done <= 1'b0;
		end else begin
			case (state)
				lcd_pkg::LOAD_IDLE: begin
					state <= lcd_pkg::LOAD_RUN;
				end
				lcd_pkg::LOAD_RUN: begin
					rom_addr <= rom_addr + 1'b1;
					wr_en    <= 1'b1;
					wr_addr  <= rom_addr;
					if (rom_addr == LAST_ADDR) begin
						state <= lcd_pkg::LOAD_DONE;
					end
				end
				lcd_pkg::LOAD_DONE: begin
					// The last word is written on this edge.
					wr_en     <= 1'b0;
					load_done <= 1'b1;
				end
				default: begin
					state <= lcd_pkg::LOAD_IDLE;
				end
			endcase
		end
	end

	a_no_write_after_load: assert property (
		@(posedge pixel_clk) disable iff (!rst)
		(state == lcd_pkg::LOAD_DONE) |=> !$rose(wr_en)
	);

endmodule

// ==== verilog/image_rom.sv ====
`timescale 1ns/1ps

module image_rom (
	input  logic                pixel_clk,
	input  lcd_pkg::cell_addr_t addr,
	output lcd_pkg::color_t     data
);

	// The image pattern is the address followed by its low byte.
	function automatic lcd_pkg::color_t rom_word(input lcd_pkg::cell_addr_t a);
		return {a, a[7:0]};
	endfunction

	lcd_pkg::color_t rom [1024];

	for (genvar i = 0; i < 1024; i++) begin : g_rom
		assign rom[i] = rom_word(lcd_pkg::cell_addr_t'(i));
	end

	always_ff @(posedge pixel_clk) begin
		data <= rom[addr];
	end

endmodule

// ==== verilog/lcd_frame.sv ====
`timescale 1ns/1ps

module lcd_frame #(
	parameter int H_ACTIVE = 480,
	parameter int H_FRONT  = 8,
	parameter int H_SYNC   = 4,
	parameter int H_TOTAL  = 525,
	parameter int V_ACTIVE = 272,
	parameter int V_FRONT  = 4,
	parameter int V_SYNC   = 4,
	parameter int V_TOTAL  = 288,
	parameter int WIN_X    = 160,
	parameter int WIN_Y    = 18
) (
	input  logic       pixel_clk,
	input  logic       rst,
	input  logic       freeze,
	output logic       lcd_clk,
	output logic       lcd_hsync,
	output logic       lcd_vsync,
	output logic       lcd_den,
	output logic [4:0] lcd_r,
	output logic [5:0] lcd_g,
	output logic [4:0] lcd_b,
	output logic       load_done
);

	lcd_pkg::scan_t      scan_t0;
	lcd_pkg::scan_t      scan_t2;
	logic                in_window2;
	lcd_pkg::cell_addr_t rd_addr;
	lcd_pkg::color_t     rd_data;
	lcd_pkg::cell_addr_t rom_addr;
	lcd_pkg::color_t     rom_data;
	logic                wr_en;
	lcd_pkg::cell_addr_t wr_addr;
	lcd_pkg::color_t     wr_data;

	// The panel samples on the same clock that drives the pipeline.
	assign lcd_clk = pixel_clk;

	lcd_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_TOTAL  (V_TOTAL)
	) i_lcd_timing (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.scan      (scan_t0)
	);

	window_addr #(
		.WIN_X (WIN_X),
		.WIN_Y (WIN_Y)
	) i_window_addr (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.scan_in   (scan_t0),
		.scan_out  (scan_t2),
		.in_window (in_window2),
		.rd_addr   (rd_addr)
	);

	video_ram i_video_ram (
		.pixel_clk (pixel_clk),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_addr   (rd_addr),
		.freeze    (freeze),
		.rd_data   (rd_data)
	);

	pixel_out i_pixel_out (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.scan      (scan_t2),
		.in_window (in_window2),
		.rd_data   (rd_data),
		.load_done (load_done),
		.lcd_hsync (lcd_hsync),
		.lcd_vsync (lcd_vsync),
		.lcd_den   (lcd_den),
		.lcd_r     (lcd_r),
		.lcd_g     (lcd_g),
		.lcd_b     (lcd_b)
	);

	image_rom i_image_rom (
		.pixel_clk (pixel_clk),
		.addr      (rom_addr),
		.data      (rom_data)
	);

	image_loader i_image_loader (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.load_done (load_done)
	);

endmodule

// ==== verilog/lcd_pkg.sv ====
package lcd_pkg;

	// Pixel and line counter values.
	typedef logic [15:0] coord_t;

	// One colour word, as stored in the ROM and the video RAM.
	typedef logic [17:0] color_t;

	// Five row-cell bits followed by five column-cell bits.
	typedef logic [9:0] cell_addr_t;

	// One scan position together with its panel controls.
	typedef struct packed {
		coord_t pixel;
		coord_t line;
		logic   den;
		logic   hsync;
		logic   vsync;
	} scan_t;

	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_RUN,
		LOAD_DONE
	} load_state_t;

endpackage

// ==== verilog/lcd_timing.sv ====
`timescale 1ns/1ps

module lcd_timing #(
	parameter int H_ACTIVE = 480,
	parameter int H_FRONT  = 8,
	parameter int H_SYNC   = 4,
	parameter int H_TOTAL  = 525,
	parameter int V_ACTIVE = 272,
	parameter int V_FRONT  = 4,
	parameter int V_SYNC   = 4,
	parameter int V_TOTAL  = 288
) (
	input  logic           pixel_clk,
	input  logic           rst,
	output lcd_pkg::scan_t scan
);

	localparam lcd_pkg::coord_t H_LAST       = lcd_pkg::coord_t'(H_TOTAL - 1);
	localparam lcd_pkg::coord_t V_LAST       = lcd_pkg::coord_t'(V_TOTAL - 1);
	localparam lcd_pkg::coord_t H_VISIBLE    = lcd_pkg::coord_t'(H_ACTIVE);
	localparam lcd_pkg::coord_t V_VISIBLE    = lcd_pkg::coord_t'(V_ACTIVE);
	localparam lcd_pkg::coord_t H_SYNC_START = lcd_pkg::coord_t'(H_ACTIVE + H_FRONT);
	localparam lcd_pkg::coord_t H_SYNC_END   = lcd_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam lcd_pkg::coord_t V_SYNC_START = lcd_pkg::coord_t'(V_ACTIVE + V_FRONT);
	localparam lcd_pkg::coord_t V_SYNC_END   = lcd_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

	lcd_pkg::coord_t pixel;
	lcd_pkg::coord_t line;

	// The line counter steps once per wrap of the pixel counter.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			pixel <= '0;
			line  <= '0;
		end else if (pixel == H_LAST) begin
			pixel <= '0;
			if (line == V_LAST) begin
				line <= '0;
			end else begin
				line <= line + 1'b1;
			end
		end else begin
			pixel <= pixel + 1'b1;
		end
	end

	always_comb begin
		scan.pixel = pixel;
		scan.line  = line;
		scan.den   = (pixel < H_VISIBLE) && (line < V_VISIBLE);
		// Both syncs are active low.
		scan.hsync = !((pixel >= H_SYNC_START) && (pixel < H_SYNC_END));
		scan.vsync = !((line >= V_SYNC_START) && (line < V_SYNC_END));
	end

	// The sync pulses must sit in the blanking interval.
	a_den_outside_hsync: assert property (
		@(posedge pixel_clk) disable iff (!rst)
		scan.den |-> scan.hsync
	);

endmodule

// ==== verilog/pixel_out.sv ====
`timescale 1ns/1ps

module pixel_out (
	input  logic            pixel_clk,
	input  logic            rst,
	input  lcd_pkg::scan_t  scan,
	input  logic            in_window,
	input  lcd_pkg::color_t rd_data,
	input  logic            load_done,
	output logic            lcd_hsync,
	output logic            lcd_vsync,
	output logic            lcd_den,
	output logic [4:0]      lcd_r,
	output logic [5:0]      lcd_g,
	output logic [4:0]      lcd_b
);

	lcd_pkg::color_t sum;
	lcd_pkg::color_t color_d;
	lcd_pkg::color_t color_q;

	assign sum = lcd_pkg::color_t'(scan.line) + lcd_pkg::color_t'(scan.pixel);

	// The window stays black until the image is loaded.
	always_comb begin
		if (!in_window) begin
			color_d = sum;
		end else if (load_done) begin
			color_d = rd_data;
		end else begin
			color_d = '0;
		end
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			color_q   <= '0;
			lcd_hsync <= 1'b1;
			lcd_vsync <= 1'b1;
			lcd_den   <= 1'b0;
		end else begin
			color_q   <= color_d;
			lcd_hsync <= scan.hsync;
			lcd_vsync <= scan.vsync;
			lcd_den   <= scan.den;
		end
	end

	// RGB565 from the top of the 18-bit word; red and blue share bits.
	assign lcd_r = color_q[17:13];
	assign lcd_g = color_q[17:12];
	assign lcd_b = color_q[17:13];

endmodule

// ==== verilog/video_ram.sv ====
`timescale 1ns/1ps

module video_ram (
	input  logic                pixel_clk,
	input  logic                wr_en,
	input  lcd_pkg::cell_addr_t wr_addr,
	input  lcd_pkg::color_t     wr_data,
	input  lcd_pkg::cell_addr_t rd_addr,
	input  logic                freeze,
	output lcd_pkg::color_t     rd_data
);

	lcd_pkg::color_t mem [1024];

	always_ff @(posedge pixel_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Freeze keeps the last word on the read port.
	always_ff @(posedge pixel_clk) begin
		if (!freeze) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// ==== verilog/window_addr.sv ====
`timescale 1ns/1ps

module window_addr #(
	parameter int WIN_X = 160,
	parameter int WIN_Y = 18
) (
	input  logic                pixel_clk,
	input  logic                rst,
	input  lcd_pkg::scan_t      scan_in,
	output lcd_pkg::scan_t      scan_out,
	output logic                in_window,
	output lcd_pkg::cell_addr_t rd_addr
);

	localparam lcd_pkg::coord_t ORIGIN_X = lcd_pkg::coord_t'(WIN_X);
	localparam lcd_pkg::coord_t ORIGIN_Y = lcd_pkg::coord_t'(WIN_Y);
	localparam lcd_pkg::coord_t WIN_SIZE = 16'd256;

	localparam lcd_pkg::scan_t SCAN_IDLE = '{
		pixel: '0,
		line:  '0,
		den:   1'b0,
		hsync: 1'b1,
		vsync: 1'b1
	};

	lcd_pkg::coord_t off_x;
	lcd_pkg::coord_t off_y;
	logic            hit;
	lcd_pkg::scan_t  scan_t1;
	logic            in_window1;

	assign off_x = scan_in.pixel - ORIGIN_X;
	assign off_y = scan_in.line - ORIGIN_Y;

	// A position left of or above the origin wraps to a large offset,
	// so one compare per axis tests both bounds.
	// The window may reach past the last active line, so blanking is masked off.
	assign hit = (off_x < WIN_SIZE) && (off_y < WIN_SIZE) && scan_in.den;

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			scan_t1    <= SCAN_IDLE;
			in_window1 <= 1'b0;
			scan_out   <= SCAN_IDLE;
			in_window  <= 1'b0;
		end else begin
			scan_t1    <= scan_in;
			in_window1 <= hit;
			scan_out   <= scan_t1;
			in_window  <= in_window1;
		end
	end

	// Cells are 8 pixels by 4 lines.
	// Bit 7 of the row offset is dropped, so the image repeats.
	always_ff @(posedge pixel_clk) begin
		rd_addr <= {off_y[6:2], off_x[7:3]};
	end

	a_window_in_active: assert property (
		@(posedge pixel_clk) disable iff (!rst)
		in_window |-> scan_out.den
	);

endmodule
